//--- Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - include
    files:
      - hdl/rv_pkg.sv
      - hdl/rv_obi_if.sv
      - hdl/rv_decoder.sv
      - hdl/rv_regfile.sv
      - hdl/rv_core.sv
      - hdl/rv_instr_log.sv
      - hdl/rv_wrapper.sv
  - target: test
    files:
      - test/rv_tb_mem.sv
      - test/tb_rv_wrapper.sv

//--- hdl/rv_core.sv
// ------------------------------
// rv core, multi-cycle RV32E subset
// fetch, execute, load/store over
// two OBI manager ports
// ------------------------------

`timescale 1ns/1ps

module rv_core (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          fetch_enable_i,
  input  rv_pkg::word_t boot_addr_i,
  rv_obi_if.manager     instr_bus,
  rv_obi_if.manager     data_bus,
  output logic          core_sleep_o,
  output logic          retire_o,
  output logic          illegal_o
);
  import rv_pkg::*;

  core_state_e state_q, state_d;
  word_t       pc_q, pc_d;
  word_t       instr_q;

  rv_op_e      op;
  reg_addr_t   rs1, rs2, rd;
  word_t       imm;
  word_t       rs1_data, rs2_data;
  word_t       alu_res, rf_wdata;
  word_t       pc_plus4, pc_target;
  logic        writes_rd, rf_we;
  logic        is_mem, branch_taken;

  rv_decoder u_decoder (
    .instr_i (instr_q),
    .op_o    (op),
    .rs1_o   (rs1),
    .rs2_o   (rs2),
    .rd_o    (rd),
    .imm_o   (imm)
  );

  rv_regfile u_regfile (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .raddr_a_i (rs1),
    .raddr_b_i (rs2),
    .waddr_i   (rd),
    .we_i      (rf_we),
    .wdata_i   (rf_wdata),
    .rdata_a_o (rs1_data),
    .rdata_b_o (rs2_data)
  );

  assign pc_plus4  = pc_q + word_t'(4);
  assign pc_target = pc_q + imm;  // branches and JAL alike
  assign is_mem    = (op == OP_LW) || (op == OP_SW);

  assign branch_taken = ((op == OP_BEQ) && (rs1_data == rs2_data)) ||
                        ((op == OP_BNE) && (rs1_data != rs2_data)) ||
                        (op == OP_JAL);

  always_comb begin
    alu_res   = '0;
    writes_rd = 1'b1;
    case (op)
      OP_LUI:  alu_res = imm;
      OP_ADDI: alu_res = rs1_data + imm;
      OP_ADD:  alu_res = rs1_data + rs2_data;
      OP_SUB:  alu_res = rs1_data - rs2_data;
      OP_AND:  alu_res = rs1_data & rs2_data;
      OP_OR:   alu_res = rs1_data | rs2_data;
      OP_XOR:  alu_res = rs1_data ^ rs2_data;
      OP_SLT:  alu_res = word_t'($signed(rs1_data) < $signed(rs2_data));
      OP_JAL:  alu_res = pc_plus4;  // link address
      OP_LW:   alu_res = '0;        // result comes from the bus
      default: writes_rd = 1'b0;
    endcase
  end

  // writeback in the retire cycle
  assign rf_we    = writes_rd && (((state_q == ST_EXEC) && !is_mem) ||
                                  ((state_q == ST_MEM_WAIT) && data_bus.rvalid));
  assign rf_wdata = (state_q == ST_MEM_WAIT) ? data_bus.rdata : alu_res;

  always_comb begin
    state_d   = state_q;
    pc_d      = pc_q;
    retire_o  = 1'b0;
    illegal_o = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (fetch_enable_i) begin
          pc_d    = boot_addr_i;
          state_d = ST_FETCH_REQ;
        end
      end
      ST_FETCH_REQ:  if (instr_bus.gnt) state_d = ST_FETCH_WAIT;
      ST_FETCH_WAIT: if (instr_bus.rvalid) state_d = ST_EXEC;
      ST_EXEC: begin
        if (is_mem) begin
          state_d = ST_MEM_REQ;
        end else begin
          retire_o  = 1'b1;
          illegal_o = (op == OP_ILLEGAL);  // skipped like a nop
          pc_d      = branch_taken ? pc_target : pc_plus4;
          state_d   = (op == OP_ECALL) ? ST_SLEEP : ST_FETCH_REQ;
        end
      end
      ST_MEM_REQ: if (data_bus.gnt) state_d = ST_MEM_WAIT;
      ST_MEM_WAIT: begin
        if (data_bus.rvalid) begin
          retire_o = 1'b1;
          pc_d     = pc_plus4;
          state_d  = ST_FETCH_REQ;
        end
      end
      ST_SLEEP: state_d = ST_SLEEP;
      default:  state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      pc_q    <= '0;
    end else begin
      state_q <= state_d;
      pc_q    <= pc_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == ST_FETCH_WAIT) && instr_bus.rvalid) begin
      instr_q <= instr_bus.rdata;
    end
  end

  // instruction side is read only
  assign instr_bus.req   = (state_q == ST_FETCH_REQ);
  assign instr_bus.addr  = pc_q;
  assign instr_bus.we    = 1'b0;
  assign instr_bus.be    = '1;
  assign instr_bus.wdata = '0;

  // operands hold still through the address phase
  assign data_bus.req   = (state_q == ST_MEM_REQ);
  assign data_bus.addr  = (rs1_data + imm) & ~word_t'(3);  // word aligned
  assign data_bus.we    = data_bus.req && (op == OP_SW);
  assign data_bus.be    = '1;
  assign data_bus.wdata = rs2_data;

  assign core_sleep_o = (state_q == ST_SLEEP);

endmodule

//--- hdl/rv_decoder.sv
// ------------------------------
// rv instruction decoder
// word to operation, register
// indices and sign-extended imm
// ------------------------------

`timescale 1ns/1ps

module rv_decoder (
  input  rv_pkg::word_t     instr_i,
  output rv_pkg::rv_op_e    op_o,
  output rv_pkg::reg_addr_t rs1_o,
  output rv_pkg::reg_addr_t rs2_o,
  output rv_pkg::reg_addr_t rd_o,
  output rv_pkg::word_t     imm_o
);
  import rv_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  logic       use_rs1, use_rs2, use_rd;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // low four bits only, bit 4 is checked below
  assign rs1_o = instr_i[18:15];
  assign rs2_o = instr_i[23:20];
  assign rd_o  = instr_i[10:7];

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  always_comb begin
    op_o    = OP_ILLEGAL;
    imm_o   = imm_i;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    use_rd  = 1'b0;
    case (opcode)
      OPC_LUI: begin
        op_o   = OP_LUI;
        imm_o  = imm_u;
        use_rd = 1'b1;
      end
      OPC_OP_IMM: begin
        if (funct3 == 3'b000) op_o = OP_ADDI;  // only ADDI of the group
        use_rs1 = 1'b1;
        use_rd  = 1'b1;
      end
      OPC_OP: begin
        case ({funct7, funct3})
          10'b0000000_000: op_o = OP_ADD;
          10'b0100000_000: op_o = OP_SUB;
          10'b0000000_010: op_o = OP_SLT;
          10'b0000000_100: op_o = OP_XOR;
          10'b0000000_110: op_o = OP_OR;
          10'b0000000_111: op_o = OP_AND;
          default:         op_o = OP_ILLEGAL;
        endcase
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        use_rd  = 1'b1;
      end
      OPC_LOAD: begin
        if (funct3 == 3'b010) op_o = OP_LW;
        use_rs1 = 1'b1;
        use_rd  = 1'b1;
      end
      OPC_STORE: begin
        if (funct3 == 3'b010) op_o = OP_SW;
        imm_o   = imm_s;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      OPC_BRANCH: begin
        if (funct3 == 3'b000) op_o = OP_BEQ;
        if (funct3 == 3'b001) op_o = OP_BNE;
        imm_o   = imm_b;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      OPC_JAL: begin
        op_o   = OP_JAL;
        imm_o  = imm_j;
        use_rd = 1'b1;
      end
      OPC_SYSTEM: if (instr_i == word_t'(32'h0000_0073)) op_o = OP_ECALL;
      default: op_o = OP_ILLEGAL;
    endcase
    // RV32E, x16 and up do not exist
    if ((use_rs1 && instr_i[19]) || (use_rs2 && instr_i[24]) || (use_rd && instr_i[11])) begin
      op_o = OP_ILLEGAL;
    end
  end

endmodule

//--- hdl/rv_instr_log.sv
// ------------------------------
// rv instruction log
// saturating retire/illegal counts
// ------------------------------

`timescale 1ns/1ps

module rv_instr_log (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         retire_i,
  input  logic         illegal_i,
  output rv_pkg::cnt_t retired_cnt_o,
  output rv_pkg::cnt_t illegal_cnt_o
);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      retired_cnt_o <= '0;
      illegal_cnt_o <= '0;
    end else begin
      // both stick at all ones
      if (retire_i && (retired_cnt_o != '1)) begin
        retired_cnt_o <= retired_cnt_o + 1'b1;
      end
      if (illegal_i && (illegal_cnt_o != '1)) begin
        illegal_cnt_o <= illegal_cnt_o + 1'b1;
      end
    end
  end

endmodule

//--- hdl/rv_obi_if.sv
// ------------------------------
// OBI bus, request/grant/rvalid
// one transaction outstanding
// ------------------------------

`timescale 1ns/1ps

interface rv_obi_if;
  import rv_pkg::*;

  logic  req;
  logic  gnt;
  logic  rvalid;  // one cycle, read data or write ack
  word_t addr;
  logic  we;
  be_t   be;
  word_t wdata;
  word_t rdata;

  modport manager (output req, addr, we, be, wdata, input gnt, rvalid, rdata);
  modport subordinate (input req, addr, we, be, wdata, output gnt, rvalid, rdata);

endinterface

//--- hdl/rv_pkg.sv
// ------------------------------
// rv core shared types
// words, register indices, opcodes
// and the controller states
// ------------------------------

`include "rv_config.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0]             word_t;
  typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_addr_t;
  typedef logic [`RV_XLEN/8-1:0]           be_t;
  typedef logic [`RV_CNT_W-1:0]            cnt_t;

  // major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    OP_LUI, OP_ADDI, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT,
    OP_LW, OP_SW, OP_BEQ, OP_BNE, OP_JAL, OP_ECALL,
    OP_ILLEGAL
  } rv_op_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH_REQ,
    ST_FETCH_WAIT,
    ST_EXEC,
    ST_MEM_REQ,   // load/store address phase
    ST_MEM_WAIT,
    ST_SLEEP      // left only by reset
  } core_state_e;

endpackage

//--- hdl/rv_regfile.sv
// ------------------------------
// rv register file, 2R1W
// x0 hardwired to zero
// ------------------------------

`timescale 1ns/1ps

`include "rv_config.svh"

module rv_regfile (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  rv_pkg::reg_addr_t raddr_a_i,
  input  rv_pkg::reg_addr_t raddr_b_i,
  input  rv_pkg::reg_addr_t waddr_i,
  input  logic              we_i,
  input  rv_pkg::word_t     wdata_i,
  output rv_pkg::word_t     rdata_a_o,
  output rv_pkg::word_t     rdata_b_o
);
  import rv_pkg::*;

  word_t regs_q [`RV_NUM_REGS];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin  // writes to x0 dropped
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

//--- hdl/rv_wrapper.sv
// ------------------------------
// rv wrapper, top level
// core and log on plain ports
// ------------------------------

`timescale 1ns/1ps

module rv_wrapper (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          fetch_enable_i,
  input  rv_pkg::word_t boot_addr_i,

  output logic          instr_req_o,
  input  logic          instr_gnt_i,
  input  logic          instr_rvalid_i,
  output rv_pkg::word_t instr_addr_o,
  input  rv_pkg::word_t instr_rdata_i,

  output logic          data_req_o,
  input  logic          data_gnt_i,
  input  logic          data_rvalid_i,
  output logic          data_we_o,
  output rv_pkg::be_t   data_be_o,
  output rv_pkg::word_t data_addr_o,
  output rv_pkg::word_t data_wdata_o,
  input  rv_pkg::word_t data_rdata_i,

  output logic          core_sleep_o,
  output rv_pkg::cnt_t  retired_cnt_o,
  output rv_pkg::cnt_t  illegal_cnt_o
);

  logic retire, illegal;

  rv_obi_if instr_bus ();
  rv_obi_if data_bus ();

  assign instr_req_o      = instr_bus.req;
  assign instr_addr_o     = instr_bus.addr;
  assign instr_bus.gnt    = instr_gnt_i;
  assign instr_bus.rvalid = instr_rvalid_i;
  assign instr_bus.rdata  = instr_rdata_i;

  assign data_req_o      = data_bus.req;
  assign data_we_o       = data_bus.we;
  assign data_be_o       = data_bus.be;
  assign data_addr_o     = data_bus.addr;
  assign data_wdata_o    = data_bus.wdata;
  assign data_bus.gnt    = data_gnt_i;
  assign data_bus.rvalid = data_rvalid_i;
  assign data_bus.rdata  = data_rdata_i;

  rv_core u_core (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .fetch_enable_i (fetch_enable_i),
    .boot_addr_i    (boot_addr_i),
    .instr_bus      (instr_bus.manager),
    .data_bus       (data_bus.manager),
    .core_sleep_o   (core_sleep_o),
    .retire_o       (retire),
    .illegal_o      (illegal)
  );

  // log sits beside the core
  rv_instr_log u_instr_log (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .retire_i      (retire),
    .illegal_i     (illegal),
    .retired_cnt_o (retired_cnt_o),
    .illegal_cnt_o (illegal_cnt_o)
  );

endmodule

//--- include/rv_config.svh
// ------------------------------
// rv core configuration
// register count and bus widths
// ------------------------------

`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data and address width
`define RV_XLEN 32

// architectural registers, RV32E
`define RV_NUM_REGS 16

`define RV_CNT_W 16  // log counter width

`endif

//--- test/rv_tb_mem.sv
// ------------------------------
// OBI memory model for the testbench
// random grant and rvalid delays
// ------------------------------

`timescale 1ns/1ps

module rv_tb_mem (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        instr_req_i,
  input  logic [31:0] instr_addr_i,
  output logic        instr_gnt_o = 1'b0,
  output logic        instr_rvalid_o = 1'b0,
  output logic [31:0] instr_rdata_o = '0,
  input  logic        data_req_i,
  input  logic        data_we_i,
  input  logic [3:0]  data_be_i,
  input  logic [31:0] data_addr_i,
  input  logic [31:0] data_wdata_i,
  output logic        data_gnt_o = 1'b0,
  output logic        data_rvalid_o = 1'b0,
  output logic [31:0] data_rdata_o = '0
);

  logic [31:0] mem [0:4095];  // shared, word indexed by addr[13:2]

  integer i_seed = 15;
  integer d_seed = 16;
  integer i_dly, d_dly;
  logic i_pend = 1'b0, d_pend = 1'b0;
  logic i_req_s, i_gnt_s, i_rst_s, d_req_s, d_gnt_s, d_rst_s, d_we_q;
  logic [31:0] i_addr_s, i_addr_q, d_addr_s, d_addr_q, d_wdata_s, d_wdata_q, d_mask_q;
  logic [3:0] d_be_s;

  always @(posedge clk_i) begin
    i_req_s  = instr_req_i;  // values the DUT sees at this edge
    i_gnt_s  = instr_gnt_o;
    i_addr_s = instr_addr_i;
    i_rst_s  = rst_n_i;
    #1;
    instr_rvalid_o = 1'b0;
    if (!i_rst_s) begin
      i_pend = 1'b0;
    end else if (i_req_s && i_gnt_s) begin
      i_pend   = 1'b1;
      i_addr_q = i_addr_s;
      i_dly    = $random(i_seed) & 3;
    end else if (i_pend) begin
      if (i_dly == 0) begin
        instr_rvalid_o = 1'b1;
        instr_rdata_o  = mem[i_addr_q[13:2]];
        i_pend         = 1'b0;
      end else begin
        i_dly = i_dly - 1;
      end
    end
    instr_gnt_o = i_rst_s && instr_req_i && !i_pend && ($random(i_seed) & 1);
  end

  always @(posedge clk_i) begin
    d_req_s   = data_req_i;
    d_gnt_s   = data_gnt_o;
    d_addr_s  = data_addr_i;
    d_wdata_s = data_wdata_i;
    d_be_s    = data_be_i;
    d_we_q    = d_pend ? d_we_q : data_we_i;
    d_rst_s   = rst_n_i;
    #1;
    data_rvalid_o = 1'b0;
    if (!d_rst_s) begin
      d_pend = 1'b0;
    end else if (d_req_s && d_gnt_s) begin
      d_pend    = 1'b1;
      d_addr_q  = d_addr_s;
      d_wdata_q = d_wdata_s;
      d_mask_q  = {{8{d_be_s[3]}}, {8{d_be_s[2]}}, {8{d_be_s[1]}}, {8{d_be_s[0]}}};
      d_dly     = $random(d_seed) & 3;
    end else if (d_pend) begin
      if (d_dly == 0) begin
        data_rvalid_o = 1'b1;
        if (d_we_q) begin
          mem[d_addr_q[13:2]] = (mem[d_addr_q[13:2]] & ~d_mask_q) | (d_wdata_q & d_mask_q);
        end
        data_rdata_o = mem[d_addr_q[13:2]];
        d_pend       = 1'b0;
      end else begin
        d_dly = d_dly - 1;
      end
    end
    data_gnt_o = d_rst_s && data_req_i && !d_pend && ($random(d_seed) & 1);
  end

endmodule

//--- test/tb_rv_wrapper.sv
// ------------------------------
// testbench for rv_wrapper
// random programs against a model
// ------------------------------

`timescale 1ns/1ps

module tb_rv_wrapper;

  localparam logic [31:0] BOOT = 32'h0000_0100;
  localparam int K_LUI = 0, K_ADDI = 1, K_ALU = 2, K_LW = 3, K_SW = 4;
  localparam int K_BEQ = 5, K_BNE = 6, K_JAL = 7, K_ECALL = 8, K_ILL = 9;

  logic clk = 1'b0, rst_n = 1'b0, fetch_en = 1'b0;
  logic instr_req, instr_gnt, instr_rvalid, data_req, data_gnt, data_rvalid, data_we;
  logic [31:0] instr_addr, instr_rdata, data_addr, data_wdata, data_rdata;
  logic [3:0] data_be;
  logic sleep;
  logic [15:0] retired_cnt, illegal_cnt;

  integer seed = 15;
  integer errors = 0;
  integer n_instr, exp_retired, exp_illegal;
  logic en_seen = 1'b0, first_fetch = 1'b1;
  int kind_a [0:127], rd_a [0:127], rs1_a [0:127], rs2_a [0:127], fn_a [0:127];
  logic [31:0] imm_a [0:127];
  logic [31:0] exp_pc [$], exp_st_addr [$], exp_st_data [$];

  rv_wrapper u_dut (
    .clk_i (clk), .rst_n_i (rst_n), .fetch_enable_i (fetch_en), .boot_addr_i (BOOT),
    .instr_req_o (instr_req), .instr_gnt_i (instr_gnt), .instr_rvalid_i (instr_rvalid),
    .instr_addr_o (instr_addr), .instr_rdata_i (instr_rdata),
    .data_req_o (data_req), .data_gnt_i (data_gnt), .data_rvalid_i (data_rvalid),
    .data_we_o (data_we), .data_be_o (data_be), .data_addr_o (data_addr),
    .data_wdata_o (data_wdata), .data_rdata_i (data_rdata),
    .core_sleep_o (sleep), .retired_cnt_o (retired_cnt), .illegal_cnt_o (illegal_cnt)
  );

  rv_tb_mem u_mem (
    .clk_i (clk), .rst_n_i (rst_n),
    .instr_req_i (instr_req), .instr_addr_i (instr_addr), .instr_gnt_o (instr_gnt),
    .instr_rvalid_o (instr_rvalid), .instr_rdata_o (instr_rdata),
    .data_req_i (data_req), .data_we_i (data_we), .data_be_i (data_be),
    .data_addr_i (data_addr), .data_wdata_i (data_wdata), .data_gnt_o (data_gnt),
    .data_rvalid_o (data_rvalid), .data_rdata_o (data_rdata)
  );

  initial forever #4 clk = ~clk;

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  function automatic logic [31:0] fill(input logic [31:0] addr);
    return {addr[15:0] ^ 16'h5a5a, ~addr[15:0]};
  endfunction

  // ALU ops as {funct7[5], funct3}: add sub slt xor or and
  function automatic logic [31:0] alu(input int fn, input logic [31:0] a, input logic [31:0] b);
    case (fn)
      0: return a + b;
      1: return a - b;
      2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3: return a ^ b;
      4: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic [31:0] encode(input int i);
    logic [31:0] m;
    logic [4:0] d, s1, s2;
    logic [2:0] f3 [0:5];
    m  = imm_a[i];
    d  = rd_a[i];
    s1 = rs1_a[i];
    s2 = rs2_a[i];
    f3 = '{3'b000, 3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
    case (kind_a[i])
      K_LUI:  return {m[31:12], d, 7'b0110111};
      K_ADDI: return {m[11:0], s1, 3'b000, d, 7'b0010011};
      K_ALU:  return {1'b0, fn_a[i] == 1, 5'b0, s2, s1, f3[fn_a[i]], d, 7'b0110011};
      K_LW:   return {m[11:0], s1, 3'b010, d, 7'b0000011};
      K_SW:   return {m[11:5], s2, s1, 3'b010, m[4:0], 7'b0100011};
      K_BEQ, K_BNE: return {m[12], m[10:5], s2, s1, 2'b00, kind_a[i] == K_BNE,
                            m[4:1], m[11], 7'b1100011};
      K_JAL:  return {m[20], m[10:1], m[11], m[19:12], d, 7'b1101111};
      K_ECALL: return 32'h0000_0073;
      default: return imm_a[i];  // illegal word kept in imm
    endcase
  endfunction

  task automatic add(input int k, input int d, input int s1, input int s2, input logic [31:0] m);
    kind_a[n_instr] = k;
    rd_a[n_instr]   = d;
    rs1_a[n_instr]  = s1;
    rs2_a[n_instr]  = s2;
    imm_a[n_instr]  = m;
    fn_a[n_instr]   = $unsigned($random(seed)) % 6;
    n_instr++;
  endtask

  task automatic build_program();
    int r;
    logic [31:0] v;
    logic [31:0] ill [0:2];
    ill = '{32'hffff_ffff, 32'h0000_0000, 32'h0000_0893};  // last one is ADDI x17
    n_instr = 0;
    for (int i = 1; i < 16; i++) begin
      v = $random(seed);
      add(K_LUI, i, 0, 0, {v[31:12], 12'b0});
      v = $random(seed);
      add(K_ADDI, i, i, 0, {{20{v[11]}}, v[11:0]});
    end
    for (int i = 0; i < 50; i++) begin
      r = $unsigned($random(seed)) % 16;
      v = $random(seed);
      if (r < 6) add(K_ALU, v[3:0], v[7:4], v[11:8], '0);
      else if (r < 8) add(K_SW, 0, 0, v[3:0], 32'h400 + {v[8:4], 2'b00});
      else if (r < 10) add(K_LW, v[3:0], 0, 0, 32'h400 + {v[8:4], 2'b00});
      else if (r < 12) add(v[12] ? K_BNE : K_BEQ, 0, v[3:0], v[7:4], v[13] ? 32'd12 : 32'd8);
      else if (r < 13) add(K_JAL, v[3:0], 0, 0, 32'd8);
      else if (r < 14) add(K_ILL, 0, 0, 0, ill[v[1:0] % 3]);
      else add(K_ADDI, v[3:0], v[7:4], 0, {{20{v[19]}}, v[19:8]});
    end
    // landing pads for a late forward branch or jump
    add(K_ADDI, 0, 0, 0, '0);
    add(K_ADDI, 0, 0, 0, '0);
    for (int i = 1; i < 16; i++) add(K_SW, 0, 0, i, 32'h600 + 4 * i);
    add(K_ECALL, 0, 0, 0, '0);
    for (int i = 0; i < 4096; i++) u_mem.mem[i] = fill(i * 4);
    for (int i = 0; i < n_instr; i++) u_mem.mem[BOOT[13:2] + i] = encode(i);
  endtask

  // instruction-set model over the structured program
  task automatic run_model();
    logic [31:0] x [0:15];
    logic [31:0] dm [0:4095];
    logic [31:0] pc, a, res;
    int i, k, steps;
    exp_pc.delete();
    exp_st_addr.delete();
    exp_st_data.delete();
    for (int j = 0; j < 16; j++) x[j] = '0;
    for (int j = 0; j < 4096; j++) dm[j] = fill(j * 4);
    pc = BOOT;
    exp_retired = 0;
    exp_illegal = 0;
    k = K_LUI;
    steps = 0;
    while (k != K_ECALL && steps < 500) begin
      i = (pc - BOOT) / 4;
      k = kind_a[i];
      exp_pc.push_back(pc);
      exp_retired++;
      steps++;
      pc = pc + 4;
      res = x[rd_a[i]];
      a = (x[rs1_a[i]] + imm_a[i]) & ~32'd3;
      case (k)
        K_LUI:  res = imm_a[i];
        K_ADDI: res = x[rs1_a[i]] + imm_a[i];
        K_ALU:  res = alu(fn_a[i], x[rs1_a[i]], x[rs2_a[i]]);
        K_LW:   res = dm[a[13:2]];
        K_SW: begin
          dm[a[13:2]] = x[rs2_a[i]];
          exp_st_addr.push_back(a);
          exp_st_data.push_back(x[rs2_a[i]]);
        end
        K_BEQ: if (x[rs1_a[i]] == x[rs2_a[i]]) pc = pc - 4 + imm_a[i];
        K_BNE: if (x[rs1_a[i]] != x[rs2_a[i]]) pc = pc - 4 + imm_a[i];
        K_JAL: begin
          res = pc;
          pc  = pc - 4 + imm_a[i];
        end
        K_ILL: exp_illegal++;
        default: ;
      endcase
      if (rd_a[i] != 0) x[rd_a[i]] = res;
    end
  endtask

  // bus monitor, sampled at the rising edge
  always @(posedge clk) begin
    if (rst_n) begin
      if ((instr_req || data_req) && !en_seen) begin
        errors++;
        $display("request issued before fetch enable");
      end
      if ((instr_req || data_req) && sleep) begin
        errors++;
        $display("request issued while the core sleeps");
      end
      if (instr_req && instr_gnt) begin
        if (first_fetch) compare("boot_addr", BOOT, instr_addr);
        first_fetch = 1'b0;
        if (exp_pc.size() == 0) begin
          errors++;
          $display("fetch beyond the end of the program trace");
        end else begin
          compare("fetch_addr", exp_pc.pop_front(), instr_addr);
        end
      end
      if (data_req && data_gnt && data_we) begin
        if (exp_st_addr.size() == 0) begin
          errors++;
          $display("store that the model does not expect");
        end else begin
          compare("store_addr", exp_st_addr.pop_front(), data_addr);
          compare("store_data", exp_st_data.pop_front(), data_wdata);
          compare("store_be", 32'hf, data_be);
        end
      end
      if (fetch_en) en_seen = 1'b1;
    end else begin
      en_seen     = 1'b0;
      first_fetch = 1'b1;
    end
  end

  task automatic apply_reset();
    @(posedge clk);
    #1 rst_n = 1'b0;
    fetch_en = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    compare("reset_instr_req", 0, instr_req);
    compare("reset_data_req", 0, data_req);
    compare("reset_sleep", 0, sleep);
    compare("reset_retired", 0, retired_cnt);
    compare("reset_illegal", 0, illegal_cnt);
    rst_n = 1'b1;
  endtask

  task automatic run_to_sleep(input string name, output logic done);
    int cycles;
    repeat (5) @(posedge clk);  // idle cycles with no request allowed
    #1 fetch_en = 1'b1;
    cycles = 0;
    while (!sleep && cycles < 20000) begin
      @(posedge clk);
      cycles++;
    end
    done = sleep;
    if (!sleep) begin
      errors++;
      $display("timeout: %s never reached sleep", name);
    end else begin
      repeat (20) @(posedge clk);
      #1;
      compare({name, "_sleep"}, 1, sleep);
      compare({name, "_retired"}, exp_retired, retired_cnt);
      compare({name, "_illegal"}, exp_illegal, illegal_cnt);
      compare({name, "_stores_left"}, 0, exp_st_addr.size());
      compare({name, "_fetches_left"}, 0, exp_pc.size());
    end
  endtask

  initial begin
    int cycles;
    logic done;
    apply_reset();
    build_program();
    run_model();
    run_to_sleep("prog1", done);
    if (done) begin
      build_program();
      run_model();
      apply_reset();
      #1 fetch_en = 1'b1;
      // partial run, then reset mid-program
      cycles = 0;
      while (retired_cnt < 16'd8 && cycles < 2000) begin
        @(posedge clk);
        cycles++;
      end
      if (retired_cnt < 16'd8) begin
        errors++;
        $display("timeout: prog2 did not get going before the mid-run reset");
      end
      apply_reset();
      for (int i = 0; i < n_instr; i++) u_mem.mem[BOOT[13:2] + i] = encode(i);
      for (int i = 256; i < 4096; i++) u_mem.mem[i] = fill(i * 4);
      run_model();
      run_to_sleep("prog2", done);
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+include
hdl/rv_pkg.sv
hdl/rv_obi_if.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_core.sv
hdl/rv_instr_log.sv
hdl/rv_wrapper.sv
test/rv_tb_mem.sv
test/tb_rv_wrapper.sv
